//--- list.f
+incdir+verilog
verilog/pktgen_csr_pkg.sv
verilog/pktgen_stream_pkg.sv
verilog/pktgen_csr.sv
verilog/pktgen_prbs23.sv
verilog/pktgen_framer.sv
verilog/pktgen_top.sv
bench/tb_pktgen.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line in the log
rm -f sim.log
{ verilator --binary --timing --assert --timescale 1ns/1ps \
     --top-module tb_pktgen -f list.f -o tb_pktgen \
  && ./obj_dir/tb_pktgen; } > sim.log 2>&1 \
  || echo "Build or simulation returned an error, see sim.log"
grep -q "Simulation finished: PASS" sim.log && exit 0 || exit 1

//--- bench/tb_pktgen.sv
// Testbench with clock, reset, register bus tasks, reference models, directed tests and verdict
`timescale 1ns/1ps
`default_nettype none

`include "pktgen_macros.svh"

module tb_pktgen;
   import pktgen_csr_pkg::*;

   localparam int TIMEOUT_CYCLES = 20000;   // Clamped frame alone is about 1200 beats

   logic                           clk;
   logic                           reset;
   logic [`PKTGEN_CSR_ADDR_W-1:0]  address;
   logic                           write;
   logic                           read;
   logic [`PKTGEN_CSR_DATA_W-1:0]  writedata;
   wire  [`PKTGEN_CSR_DATA_W-1:0]  readdata;
   wire                            waitrequest;
   logic                           tx_ready;
   wire  [`PKTGEN_DATA_W-1:0]      tx_data;
   wire                            tx_valid;
   wire                            tx_sop;
   wire                            tx_eop;
   wire  [2:0]                     tx_empty;

   // Settings as last written for the frame model
   logic [13:0]  fl_m;
   logic         rnd_m;
   logic [47:0]  da_m;
   logic [47:0]  sa_m;
   logic [68:0]  seed_m;                    // {seed2, seed1, seed0}
   logic [68:0]  prbs_m;                    // PRBS model with three 23-bit lanes
   logic [15:0]  lfsr;                      // Back-pressure source
   int           errors;
   int           cycles = 0;

   pktgen_top dut (
      .clk (clk), .reset (reset),
      .address (address), .write (write), .read (read), .writedata (writedata),
      .readdata (readdata), .waitrequest (waitrequest),
      .tx_ready (tx_ready), .tx_data (tx_data), .tx_valid (tx_valid),
      .tx_sop (tx_sop), .tx_eop (tx_eop), .tx_empty (tx_empty)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;               // 100 ns period
   end

   // Watchdog
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("Timeout: no progress from the DUT after %0d cycles", cycles);
         $display("Simulation finished: FAIL");
         $fatal(1, "watchdog expired");
      end
   end

   // -------------------------------------------------------------------------
   // Reference models
   // -------------------------------------------------------------------------
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return s[0] ? (s >> 1) ^ 16'hB400 : s >> 1;   // Taps 16 14 13 11
   endfunction

   // PRBS model for x^23 + x^18 + 1 with 23 right shifts per step
   function automatic logic [22:0] prbs_step(input logic [22:0] s);
      logic [22:0] r;
      r = s;
      for (int i = 0; i < 23; i++) begin
         r = {r[18] ^ r[0], r[22:1]};
      end
      return r;
   endfunction

   function automatic int payload_len(input logic [13:0] fl);
      if (fl < 24) return 0;
      if (fl > 9600) return 9582;           // Clamped at the top
      return fl - 18;
   endfunction

   // Beat k of a frame as {data, valid, sop, eop, empty}
   function automatic logic [69:0] frame_beat(input int k, input int len,
                                              input logic [15:0] seq);
      logic [63:0] data;
      int          n;
      int          last;
      n    = k - 2;                         // Payload beat index
      last = (len + 7) / 8 - 1;
      if (k == 0) return {da_m, sa_m[47:32], 1'b1, 1'b1, 1'b0, 3'd0};
      if (k == 1) return {sa_m[31:0], 16'(len + 6), seq, 1'b1, 1'b0, len == 0, 3'd0};
      for (int i = 0; i < 8; i++) begin
         data[63-8*i -: 8] = 8'(8*n + i);   // Byte 0 on top
      end
      if (rnd_m) data = prbs_m[63:0];
      return {data, 1'b1, 1'b0, n == last, n == last ? 3'((8 - len % 8) % 8) : 3'd0};
   endfunction

   // -------------------------------------------------------------------------
   // Checker and bus tasks
   // -------------------------------------------------------------------------
   task automatic check_eq(input string name, input logic [69:0] exp, input logic [69:0] act);
      if (exp !== act) begin
         errors++;
         $display("FAILED %s expected %0h actual %0h", name, exp, act);
         $display("Simulation finished: FAIL");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic csr_write(input logic [7:0] addr, input logic [31:0] data);
      @(negedge clk);
      address   = addr;
      writedata = data;
      write     = 1'b1;
      #1 check_eq("csr_write waitrequest", 70'(1), 70'(waitrequest));
      case (addr)                           // Track settings for the model
         FRAME_LENGTH:   fl_m = data[13:0];
         PAYLOAD_RANDOM: rnd_m = data[0];
         MAC_SA_LO:      sa_m[31:0] = data;
         MAC_SA_HI:      sa_m[47:32] = data[15:0];
         MAC_DA_LO:      da_m[31:0] = data;
         MAC_DA_HI:      da_m[47:32] = data[15:0];
         SEED0:          seed_m[31:0] = data;
         SEED1:          seed_m[63:32] = data;
         SEED2:          seed_m[68:64] = data[4:0];
         START:          if (data[0]) prbs_m = seed_m;   // Generators reload while idle
         default: ;
      endcase
      @(negedge clk);
      write = 1'b0;
   endtask

   task automatic csr_read(input logic [7:0] addr, output logic [31:0] data);
      @(negedge clk);
      address = addr;
      read    = 1'b1;
      #1 check_eq("csr_read waitrequest", 70'(1), 70'(waitrequest));
      @(negedge clk);
      check_eq("csr_read second cycle", 70'(0), 70'(waitrequest));
      @(negedge clk);
      read = 1'b0;
      data = readdata;                      // Registered at the last edge and held
   endtask

   task automatic read_expect(input string name, input logic [7:0] addr, input logic [31:0] exp);
      logic [31:0] d;
      csr_read(addr, d);
      check_eq(name, 70'(exp), 70'(d));
   endtask

   // Follow one frame and check every accepted and every held beat
   task automatic collect_frame(input string name, input logic [15:0] seq, input bit bp);
      int          k;
      int          len;
      int          beats;
      logic [69:0] held;
      logic        holding;
      k       = 0;
      len     = payload_len(fl_m);
      beats   = 2 + (len + 7) / 8;
      holding = 1'b0;
      while (k < beats) begin
         @(negedge clk);
         if (holding) begin
            check_eq({name, " hold"}, held, {tx_data, tx_valid, tx_sop, tx_eop, tx_empty});
         end
         if (k > 0) begin                   // No bubble inside a frame
            check_eq({name, " contiguous"}, 70'(1), 70'(tx_valid));
         end
         if (bp) begin
            lfsr     = lfsr_step(lfsr);
            tx_ready = lfsr[0];
         end else begin
            tx_ready = 1'b1;
         end
         holding = tx_valid & ~tx_ready;
         held    = {tx_data, tx_valid, tx_sop, tx_eop, tx_empty};
         if (tx_valid && tx_ready) begin    // Accepted at the coming edge
            check_eq($sformatf("%s seq %0d beat %0d", name, seq, k),
                     frame_beat(k, len, seq), held);
            if (k >= 2 && rnd_m) begin
               prbs_m = {prbs_step(prbs_m[68:46]), prbs_step(prbs_m[45:23]),
                         prbs_step(prbs_m[22:0])};
            end
            k++;
         end
      end
      @(negedge clk);
      check_eq({name, " gap"}, 70'(0), 70'(tx_valid));   // Idle beat after eop
   endtask

   // -------------------------------------------------------------------------
   // Directed tests
   // -------------------------------------------------------------------------
   task automatic test_registers;
      check_eq("reset outputs", 70'(0), {tx_data, tx_valid, tx_sop, tx_eop, tx_empty});
      check_eq("reset waitrequest", 70'(0), 70'(waitrequest));
      read_expect("reset SEED0", SEED0, `PKTGEN_SEED0_RST);
      read_expect("reset SEED1", SEED1, `PKTGEN_SEED1_RST);
      read_expect("reset SEED2", SEED2, `PKTGEN_SEED2_RST);
      read_expect("reset NUM_FRAMES", NUM_FRAMES, 32'd0);
      read_expect("reset TX_COUNT", TX_COUNT, 32'd0);
      csr_write(NUM_FRAMES, 32'hCAFE_0003);
      csr_write(MAC_SA_LO, 32'h3344_5566);
      csr_write(MAC_SA_HI, 32'hFFFF_1122);
      csr_write(MAC_DA_LO, 32'h9ABC_DEF0);
      csr_write(MAC_DA_HI, 32'h1234_5678);
      csr_write(SEED2, 32'hFFFF_FFF3);
      csr_write(FRAME_LENGTH, 32'd45);
      read_expect("NUM_FRAMES", NUM_FRAMES, 32'hCAFE_0003);
      read_expect("MAC_SA_LO", MAC_SA_LO, 32'h3344_5566);
      read_expect("MAC_SA_HI masked", MAC_SA_HI, 32'h0000_1122);
      read_expect("MAC_DA_HI masked", MAC_DA_HI, 32'h0000_5678);
      read_expect("SEED2 masked", SEED2, 32'h0000_0013);
      read_expect("FRAME_LENGTH", FRAME_LENGTH, 32'd45);
      read_expect("START", START, 32'd0);
      read_expect("hole 01", 8'h01, 32'd0);
      read_expect("hole FF", 8'hFF, 32'd0);
   endtask

   task automatic test_single_frame;
      csr_write(NUM_FRAMES, 32'd1);
      csr_write(FRAME_LENGTH, 32'd45);      // L 27 gives length field 33 and empty 5
      csr_write(START, 32'd1);
      collect_frame("single frame", 16'd0, 1'b0);
   endtask

   task automatic test_backpressure;
      csr_write(NUM_FRAMES, 32'd3);
      csr_write(FRAME_LENGTH, 32'd70);
      csr_write(START, 32'd1);
      for (int s = 0; s < 3; s++) collect_frame("backpressure", 16'(s), 1'b1);
      tx_ready = 1'b1;
      read_expect("backpressure TX_COUNT", TX_COUNT, 32'd3);
   endtask

   task automatic test_random_payload;
      csr_write(SEED0, 32'h1357_9BDF);
      csr_write(SEED1, 32'h2468_ACE0);
      csr_write(SEED2, 32'h0000_001B);
      csr_write(PAYLOAD_RANDOM, 32'd1);
      csr_write(NUM_FRAMES, 32'd2);
      csr_write(FRAME_LENGTH, 32'd61);
      csr_write(START, 32'd1);
      collect_frame("random payload", 16'd0, 1'b1);
      collect_frame("random payload", 16'd1, 1'b1);   // PRBS runs on across frames
      tx_ready = 1'b1;
      csr_write(PAYLOAD_RANDOM, 32'd0);
   endtask

   task automatic test_length_clamp;
      csr_write(NUM_FRAMES, 32'd1);
      csr_write(FRAME_LENGTH, 32'd10);      // Header only
      csr_write(START, 32'd1);
      collect_frame("short frame", 16'd0, 1'b0);
      csr_write(FRAME_LENGTH, 32'd9700);    // Length field 9588 and 1198 payload beats
      csr_write(START, 32'd1);
      collect_frame("long frame", 16'd0, 1'b0);
   endtask

   task automatic test_stop;
      csr_write(NUM_FRAMES, 32'd100);
      csr_write(FRAME_LENGTH, 32'd64);
      tx_ready = 1'b0;                      // Hold beat 0 while stop goes in
      csr_write(START, 32'd1);
      do @(negedge clk); while (!tx_sop);
      csr_write(STOP, 32'd1);
      collect_frame("stop", 16'd0, 1'b0);
      repeat (20) begin
         @(negedge clk);
         check_eq("stop idle", 70'(0), 70'(tx_valid));
      end
      read_expect("stop TX_COUNT", TX_COUNT, 32'd1);
   endtask

   // -------------------------------------------------------------------------
   // Main sequence
   // -------------------------------------------------------------------------
   initial begin
      reset     = 1'b1;
      address   = '0;
      write     = 1'b0;
      read      = 1'b0;
      writedata = '0;
      tx_ready  = 1'b0;
      lfsr      = 16'd14;
      errors    = 0;
      fl_m      = '0;
      rnd_m     = 1'b0;
      da_m      = '0;
      sa_m      = '0;
      seed_m    = {5'(`PKTGEN_SEED2_RST), `PKTGEN_SEED1_RST, `PKTGEN_SEED0_RST};
      prbs_m    = seed_m;
      repeat (4) @(negedge clk);
      reset = 1'b0;
      test_registers();
      test_single_frame();
      test_backpressure();
      test_random_payload();
      test_length_clamp();
      test_stop();
      if (errors == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog/pktgen_top.sv
// Top level joining the register block and the framer to the external ports
`timescale 1ns/1ps
`default_nettype none

`include "pktgen_macros.svh"

module pktgen_top (
   input  wire                            clk,
   input  wire                            reset,

   // Register port
   input  wire [`PKTGEN_CSR_ADDR_W-1:0]   address,
   input  wire                            write,
   input  wire                            read,
   input  wire [`PKTGEN_CSR_DATA_W-1:0]   writedata,
   output wire [`PKTGEN_CSR_DATA_W-1:0]   readdata,
   output wire                            waitrequest,

   // Stream port
   input  wire                            tx_ready,
   output wire [`PKTGEN_DATA_W-1:0]       tx_data,
   output wire                            tx_valid,
   output wire                            tx_sop,
   output wire                            tx_eop,
   output wire [2:0]                      tx_empty
);
   import pktgen_csr_pkg::*;
   import pktgen_stream_pkg::*;

   gen_cfg_t                       cfg;
   st_beat_t                       beat;
   logic                           start_pulse;
   logic [`PKTGEN_CSR_DATA_W-1:0]  tx_count;

   pktgen_csr u_csr (
      .clk         (clk),
      .reset       (reset),
      .address     (csr_addr_e'(address)),
      .write       (write),
      .read        (read),
      .writedata   (writedata),
      .tx_count    (tx_count),
      .readdata    (readdata),
      .waitrequest (waitrequest),
      .cfg         (cfg),
      .start_pulse (start_pulse)
   );

   pktgen_framer u_framer (
      .clk         (clk),
      .reset       (reset),
      .cfg         (cfg),
      .start_pulse (start_pulse),
      .tx_ready    (tx_ready),
      .beat        (beat),
      .tx_count    (tx_count)
   );

   // Beat fields onto the stream pins
   assign tx_data  = beat.data;
   assign tx_valid = beat.valid;
   assign tx_sop   = beat.sop;
   assign tx_eop   = beat.eop;
   assign tx_empty = beat.empty;

endmodule

`default_nettype wire

//--- verilog/pktgen_framer.sv
// Frame FSM, length clamp, sequence and payload pattern, output beat register
`timescale 1ns/1ps
`default_nettype none

`include "pktgen_macros.svh"

module pktgen_framer (
   input  wire                            clk,
   input  wire                            reset,
   input  wire pktgen_csr_pkg::gen_cfg_t  cfg,
   input  wire                            start_pulse,
   input  wire                            tx_ready,
   output pktgen_stream_pkg::st_beat_t    beat,
   output logic [`PKTGEN_CSR_DATA_W-1:0]  tx_count
);
   import pktgen_stream_pkg::*;

   frame_state_e                   state;
   logic [`PKTGEN_LEN_W-1:0]       pay_len;      // Clamped payload length L
   logic [`PKTGEN_LEN_W-1:0]       remain;       // Payload bytes not yet loaded
   logic [`PKTGEN_LEN_W-1:0]       seq_num;
   logic [7:0]                     inc_base;     // First byte of next incrementing beat
   logic [`PKTGEN_LEN_W-1:0]       len_clamp;
   logic [`PKTGEN_DATA_W-1:0]      inc_data;
   logic [`PKTGEN_DATA_W-1:0]      pay_data;
   logic [3*`PKTGEN_PRBS_W-1:0]    prbs_state;
   logic [`PKTGEN_CSR_DATA_W-1:0]  count_nxt;
   logic                           take;         // Beat accepted this cycle
   logic                           pay_load;     // Payload beat loaded this cycle
   logic                           last_pay;
   logic                           run_done;

   // ------------------------------------------------------------------------
   // Payload length from the frame length setting
   // ------------------------------------------------------------------------
   always_comb begin
      if (cfg.frame_length < 14'(`PKTGEN_MIN_FRAME)) begin
         len_clamp = '0;
      end else if (cfg.frame_length > 14'(`PKTGEN_MAX_FRAME)) begin
         len_clamp = 16'(`PKTGEN_MAX_FRAME - `PKTGEN_HDR_BYTES);   // 9582
      end else begin
         len_clamp = 16'(cfg.frame_length) - 16'(`PKTGEN_HDR_BYTES);
      end
   end

   // Incrementing bytes, byte 0 in the top lane
   always_comb begin
      for (int i = 0; i < 8; i++) begin
         inc_data[`PKTGEN_DATA_W-1-8*i -: 8] = inc_base + 8'(i);
      end
   end

   assign pay_data  = cfg.payload_random ? prbs_state[`PKTGEN_DATA_W-1:0] : inc_data;
   assign take      = beat.valid & tx_ready;
   assign pay_load  = take & ~beat.eop & (state == HDR_LEN || state == PAYLOAD);
   assign last_pay  = (remain <= 16'd8);
   assign count_nxt = tx_count + 32'(take && state == HDR_LEN);   // Beat 1 counts
   assign run_done  = cfg.stop | (count_nxt == cfg.num_frames);

   // ------------------------------------------------------------------------
   // PRBS generators, reloaded while idle, stepped per payload beat loaded
   // ------------------------------------------------------------------------
   for (genvar g = 0; g < 3; g++) begin : g_prbs
      pktgen_prbs23 u_prbs (
         .clk    (clk),
         .reset  (reset),
         .load   (state == IDLE),
         .enable (pay_load),
         .seed   (cfg.seed[g*`PKTGEN_PRBS_W +: `PKTGEN_PRBS_W]),
         .state  (prbs_state[g*`PKTGEN_PRBS_W +: `PKTGEN_PRBS_W])
      );
   end

   // ------------------------------------------------------------------------
   // Frame FSM and output beat register
   // ------------------------------------------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state    <= IDLE;
         beat     <= '0;
         pay_len  <= '0;
         remain   <= '0;
         seq_num  <= '0;
         inc_base <= '0;
         tx_count <= '0;
      end else begin
         case (state)
            IDLE: begin
               if (start_pulse) begin           // Ignored once a run is going
                  state    <= HDR_ADDR;
                  pay_len  <= len_clamp;
                  seq_num  <= '0;
                  tx_count <= '0;
               end
            end
            HDR_ADDR: begin
               if (!beat.valid) begin           // Gap over, present beat 0
                  beat <= '{data:  {cfg.mac_da, cfg.mac_sa[47:32]},
                            valid: 1'b1,
                            sop:   1'b1,
                            eop:   1'b0,
                            empty: 3'd0};
               end else if (tx_ready) begin
                  beat.data <= {cfg.mac_sa[31:0], pay_len + 16'd6, seq_num};
                  beat.sop  <= 1'b0;
                  beat.eop  <= (pay_len == '0); // Header only frame
                  remain    <= pay_len;
                  inc_base  <= '0;
                  state     <= HDR_LEN;
               end
            end
            default: begin                      // HDR_LEN and PAYLOAD
               if (take) begin
                  tx_count <= count_nxt;
                  if (beat.eop) begin
                     // Frame done, one idle beat before the next one
                     beat.valid <= 1'b0;
                     beat.eop   <= 1'b0;
                     beat.empty <= 3'd0;
                     seq_num    <= seq_num + 16'd1;
                     pay_len    <= len_clamp;
                     state      <= run_done ? IDLE : HDR_ADDR;
                  end else begin
                     beat.data  <= pay_data;
                     beat.eop   <= last_pay;
                     beat.empty <= last_pay ? 3'd0 - remain[2:0] : 3'd0;
                     remain     <= remain - 16'd8;
                     inc_base   <= inc_base + 8'd8;
                     state      <= PAYLOAD;
                  end
               end
            end
         endcase
      end
   end

   a_empty_eop: assert property (@(posedge clk) disable iff (reset)
      beat.valid && beat.empty != 3'd0 |-> beat.eop);

   // Back-pressure freezes the whole beat
   a_hold: assert property (@(posedge clk) disable iff (reset)
      beat.valid && !tx_ready |=> $stable(beat));

endmodule

`default_nettype wire

//--- verilog/pktgen_prbs23.sv
// 23-bit PRBS generator advancing 23 bit steps per enable
`timescale 1ns/1ps
`default_nettype none

`include "pktgen_macros.svh"

module pktgen_prbs23 (
   input  wire                        clk,
   input  wire                        reset,
   input  wire                        load,      // Seed load, wins over enable
   input  wire                        enable,
   input  wire [`PKTGEN_PRBS_W-1:0]   seed,
   output logic [`PKTGEN_PRBS_W-1:0]  state
);

   localparam int TAP = 18;                      // x^18 term

   logic [`PKTGEN_PRBS_W-1:0] state_nxt;

   // Unrolled right shifts, new top bit from the tap and bit 0
   always_comb begin
      state_nxt = state;
      for (int i = 0; i < `PKTGEN_PRBS_W; i++) begin
         state_nxt = {state_nxt[TAP] ^ state_nxt[0], state_nxt[`PKTGEN_PRBS_W-1:1]};
      end
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state <= '0;
      end else if (load) begin
         state <= seed;
      end else if (enable) begin
         state <= state_nxt;
      end
   end

endmodule

`default_nettype wire

//--- verilog/pktgen_csr.sv
// Settings registers, readback mux, waitrequest pulse and start edge detect
`timescale 1ns/1ps
`default_nettype none

`include "pktgen_macros.svh"

module pktgen_csr (
   input  wire                             clk,
   input  wire                             reset,
   input  wire pktgen_csr_pkg::csr_addr_e  address,
   input  wire                             write,
   input  wire                             read,
   input  wire [`PKTGEN_CSR_DATA_W-1:0]    writedata,
   input  wire [`PKTGEN_CSR_DATA_W-1:0]    tx_count,     // From the framer
   output logic [`PKTGEN_CSR_DATA_W-1:0]   readdata,
   output logic                            waitrequest,
   output pktgen_csr_pkg::gen_cfg_t        cfg,
   output logic                            start_pulse
);
   import pktgen_csr_pkg::*;

   logic [`PKTGEN_CSR_DATA_W-1:0] num_frames;
   logic [13:0]                   frame_length;
   logic                          payload_random;
   logic                          stop;
   logic [31:0]                   mac_sa_lo;
   logic [15:0]                   mac_sa_hi;
   logic [31:0]                   mac_da_lo;
   logic [15:0]                   mac_da_hi;
   logic [31:0]                   seed0;
   logic [31:0]                   seed1;
   logic [4:0]                    seed2;
   logic                          start_reg;   // Self clearing start bit
   logic                          start_d;
   logic                          access_d;    // Strobe seen last cycle

   // ------------------------------------------------------------------------
   // Register writes
   // ------------------------------------------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         num_frames     <= '0;
         frame_length   <= '0;
         payload_random <= 1'b0;
         stop           <= 1'b0;
         mac_sa_lo      <= '0;
         mac_sa_hi      <= '0;
         mac_da_lo      <= '0;
         mac_da_hi      <= '0;
         seed0          <= `PKTGEN_SEED0_RST;
         seed1          <= `PKTGEN_SEED1_RST;
         seed2          <= 5'(`PKTGEN_SEED2_RST);
         start_reg      <= 1'b0;
      end else begin
         start_reg <= 1'b0;                     // Clears itself next cycle
         if (write) begin
            case (address)
               NUM_FRAMES:     num_frames     <= writedata;
               PAYLOAD_RANDOM: payload_random <= writedata[0];
               START:          start_reg      <= writedata[0];
               STOP:           stop           <= writedata[0];   // Level
               MAC_SA_LO:      mac_sa_lo      <= writedata;
               MAC_SA_HI:      mac_sa_hi      <= writedata[15:0];
               MAC_DA_LO:      mac_da_lo      <= writedata;
               MAC_DA_HI:      mac_da_hi      <= writedata[15:0];
               SEED0:          seed0          <= writedata;
               SEED1:          seed1          <= writedata;
               SEED2:          seed2          <= writedata[4:0];
               FRAME_LENGTH:   frame_length   <= writedata[13:0];
               default: ;                       // TX_COUNT is read only
            endcase
         end
      end
   end

   // Edge detect on the start bit, one pulse per write of 1
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         start_d  <= 1'b0;
         access_d <= 1'b0;
      end else begin
         start_d  <= start_reg;
         access_d <= read | write;
      end
   end

   assign start_pulse = start_reg & ~start_d;
   assign waitrequest = (read | write) & ~access_d;   // First cycle of an access

   // ------------------------------------------------------------------------
   // Readback, registered and held until the next read
   // ------------------------------------------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         readdata <= '0;
      end else if (read) begin
         case (address)
            NUM_FRAMES:     readdata <= num_frames;
            PAYLOAD_RANDOM: readdata <= 32'(payload_random);
            STOP:           readdata <= 32'(stop);
            MAC_SA_LO:      readdata <= mac_sa_lo;
            MAC_SA_HI:      readdata <= 32'(mac_sa_hi);
            MAC_DA_LO:      readdata <= mac_da_lo;
            MAC_DA_HI:      readdata <= 32'(mac_da_hi);
            TX_COUNT:       readdata <= tx_count;
            SEED0:          readdata <= seed0;
            SEED1:          readdata <= seed1;
            SEED2:          readdata <= 32'(seed2);
            FRAME_LENGTH:   readdata <= 32'(frame_length);
            default:        readdata <= '0;     // START and holes
         endcase
      end
   end

   assign cfg = '{num_frames:     num_frames,
                  frame_length:   frame_length,
                  payload_random: payload_random,
                  stop:           stop,
                  mac_da:         {mac_da_hi, mac_da_lo},
                  mac_sa:         {mac_sa_hi, mac_sa_lo},
                  seed:           {seed2, seed1, seed0}};

   // Back to back start writes still give isolated pulses
   a_start_single: assert property (@(posedge clk) disable iff (reset)
      start_pulse |=> !start_pulse);

endmodule

`default_nettype wire

//--- verilog/pktgen_stream_pkg.sv
// Framer state encoding and stream beat struct
`default_nettype none

`include "pktgen_macros.svh"

package pktgen_stream_pkg;

   // ------------------------------------------------------------------------
   // Framer states
   // ------------------------------------------------------------------------
   // The state names the kind of beat held in the output register;
   // HDR_ADDR with valid low is the gap before a frame
   typedef enum logic [1:0] {
      IDLE     = 2'd0,
      HDR_ADDR = 2'd1,   // Beat 0, DA and SA high
      HDR_LEN  = 2'd2,   // Beat 1, SA low, length, sequence
      PAYLOAD  = 2'd3
   } frame_state_e;

   // ------------------------------------------------------------------------
   // One stream beat
   // ------------------------------------------------------------------------
   typedef struct packed {
      logic [`PKTGEN_DATA_W-1:0] data;    // Byte 0 in the top bits
      logic                      valid;
      logic                      sop;
      logic                      eop;
      logic [2:0]                empty;   // Unused bytes on the eop beat
   } st_beat_t;

endpackage

`default_nettype wire

//--- verilog/pktgen_csr_pkg.sv
// Register address map and configuration struct for the generator registers
`default_nettype none

`include "pktgen_macros.svh"

package pktgen_csr_pkg;

   // Register addresses, gaps read as zero
   typedef enum logic [`PKTGEN_CSR_ADDR_W-1:0] {
      NUM_FRAMES     = 8'h00,
      PAYLOAD_RANDOM = 8'h02,
      START          = 8'h03,   // Self clearing
      STOP           = 8'h04,
      MAC_SA_LO      = 8'h05,
      MAC_SA_HI      = 8'h06,   // 16 bits
      MAC_DA_LO      = 8'h07,
      MAC_DA_HI      = 8'h08,   // 16 bits
      TX_COUNT       = 8'h09,   // Read only
      SEED0          = 8'h0A,
      SEED1          = 8'h0B,
      SEED2          = 8'h0C,   // 5 bits
      FRAME_LENGTH   = 8'h0D
   } csr_addr_e;

   // Settings handed from the register block to the framer
   typedef struct packed {
      logic [`PKTGEN_CSR_DATA_W-1:0]  num_frames;
      logic [13:0]                    frame_length;
      logic                           payload_random;   // 0 incrementing, 1 PRBS
      logic                           stop;
      logic [47:0]                    mac_da;
      logic [47:0]                    mac_sa;
      logic [3*`PKTGEN_PRBS_W-1:0]    seed;             // {seed2, seed1, seed0}
   } gen_cfg_t;

endpackage

`default_nettype wire

//--- verilog/pktgen_macros.svh
// Width and limit macros plus reset seed values for the test frame generator
`ifndef PKTGEN_MACROS_SVH
`define PKTGEN_MACROS_SVH

// ---------------------------------------------------------------------------
// Bus widths
// ---------------------------------------------------------------------------
`define PKTGEN_DATA_W      64       // Stream beat width
`define PKTGEN_CSR_ADDR_W  8        // Register address width
`define PKTGEN_CSR_DATA_W  32       // Register data width
`define PKTGEN_LEN_W       16       // Length and sequence fields

// ---------------------------------------------------------------------------
// Frame length limits
// ---------------------------------------------------------------------------
`define PKTGEN_MIN_FRAME   24       // Below this the payload is empty
`define PKTGEN_MAX_FRAME   9600     // Longest frame, larger settings clamp here
`define PKTGEN_HDR_BYTES   18       // Header plus trailer bytes

// PRBS generator width, x^23 + x^18 + 1
`define PKTGEN_PRBS_W      23

// Nonzero seeds so the random payload runs without any seed write
`define PKTGEN_SEED0_RST   32'h5EED_0000
`define PKTGEN_SEED1_RST   32'h5EED_0001
`define PKTGEN_SEED2_RST   32'h0000_000D

`endif
